// ==== include/huff_defs.svh ====
`ifndef HUFF_DEFS_SVH
`define HUFF_DEFS_SVH

// source and output word width
`define HUFF_WORD_W 32

// longest code in the table, in bits
`define HUFF_MAX_CODE_LEN 16

// code length field, holds 0 to 16
`define HUFF_LEN_W 5

// fifo depths, input and output side
`define HUFF_IN_DEPTH 16
`define HUFF_OUT_DEPTH 16

// byte counter width
`define HUFF_MSG_LEN_W 32

`endif

// ==== rtl/huff_pkg.sv ====
`include "huff_defs.svh"

package huff_pkg;

	//////////////////////////////
	// stream payloads
	//////////////////////////////

	// one source word, nbytes is 1 to 4, taken from the top byte down
	typedef struct packed {
		logic [`HUFF_WORD_W-1:0] data;
		logic [2:0]              nbytes;
		logic                    last;
	} in_beat_t;

	// one byte symbol
	typedef struct packed {
		logic [7:0] sym;
		logic       last;
	} sym_beat_t;

	// table entry, bits right-aligned
	typedef struct packed {
		logic [`HUFF_LEN_W-1:0]        len;
		logic [`HUFF_MAX_CODE_LEN-1:0] bits;
	} code_t;

	// table entry travelling with its last flag
	typedef struct packed {
		code_t code;
		logic  last;
	} code_beat_t;

	// packed output word
	typedef logic [`HUFF_WORD_W-1:0] word_t;

endpackage

// ==== rtl/huff_fifo.sv ====
module huff_fifo #(
	parameter type payload_t = logic,
	parameter int  depth     = 16
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     wr_valid,
	input  payload_t wr_data,
	output logic     wr_ready,
	output logic     rd_valid,
	output payload_t rd_data,
	input  logic     rd_ready
);
	localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
	localparam int CNT_W = $clog2(depth + 1);

	payload_t         mem [depth];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wrap at depth, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign wr_ready = (count != CNT_W'(depth));
	assign rd_valid = (count != '0);
	// show-ahead, head word always on the output
	assign rd_data  = mem[rd_ptr];
	assign push     = wr_valid & wr_ready;
	assign pop      = rd_valid & rd_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== rtl/huff_byte_split.sv ====
`include "huff_defs.svh"

module huff_byte_split (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       in_valid,
	input  huff_pkg::in_beat_t         in_beat,
	output logic                       in_ready,
	output logic                       sym_valid,
	output huff_pkg::sym_beat_t        sym,
	input  logic                       sym_ready,
	output logic [`HUFF_MSG_LEN_W-1:0] msg_len
);
	localparam int MSG_W = `HUFF_MSG_LEN_W;

	huff_pkg::in_beat_t beat_q;
	logic               busy_q;
	logic [1:0]         idx_q;
	logic [1:0]         byte_sel;
	logic               last_byte;
	logic               emit;
	logic               take;
	logic               new_msg_q;

	// index 0 is the top byte
	assign byte_sel  = ~idx_q;
	assign last_byte = ({1'b0, idx_q} == beat_q.nbytes - 3'd1);
	assign emit      = sym_valid & sym_ready;

	// next beat may load while the last byte of this one leaves
	assign in_ready  = ~busy_q | (sym_ready & last_byte);
	assign take      = in_valid & in_ready;

	assign sym_valid = busy_q;
	assign sym.sym   = beat_q.data[{byte_sel, 3'b000} +: 8];
	assign sym.last  = beat_q.last & last_byte;

	//////////////////////////////
	// beat holding and byte walk
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (take) begin
			beat_q <= in_beat;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy_q <= 1'b0;
			idx_q  <= 2'd0;
		end else if (take) begin
			busy_q <= 1'b1;
			idx_q  <= 2'd0;
		end else if (emit) begin
			if (last_byte) begin
				busy_q <= 1'b0;
			end
			idx_q <= idx_q + 2'd1;
		end
	end

	//////////////////////////////
	// message byte count
	//////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			msg_len   <= '0;
			new_msg_q <= 1'b1;
		end else if (emit) begin
			// first byte after a last restarts the count
			msg_len   <= new_msg_q ? MSG_W'(1) : msg_len + 1'b1;
			new_msg_q <= sym.last;
		end
	end

endmodule

// ==== rtl/huff_code_lookup.sv ====
module huff_code_lookup (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 tbl_wr,
	input  logic [7:0]           tbl_sym,
	input  huff_pkg::code_t      tbl_code,
	input  logic                 sym_valid,
	input  huff_pkg::sym_beat_t  sym,
	output logic                 sym_ready,
	output logic                 code_valid,
	output huff_pkg::code_beat_t code,
	input  logic                 code_ready
);
	huff_pkg::code_t code_mem [256];
	logic            accept;

	// single stage, moves when empty or drained
	assign sym_ready = ~code_valid | code_ready;
	assign accept    = sym_valid & sym_ready;

	//////////////////////////////
	// code table
	//////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 256; i++) begin
				code_mem[i] <= '0;
			end
		end else if (tbl_wr) begin
			code_mem[tbl_sym] <= tbl_code;
		end
	end

	//////////////////////////////
	// lookup register
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (accept) begin
			code.code <= code_mem[sym.sym];
			code.last <= sym.last;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			code_valid <= 1'b0;
		end else if (accept) begin
			code_valid <= 1'b1;
		end else if (code_ready) begin
			code_valid <= 1'b0;
		end
	end

endmodule

// ==== rtl/huff_bit_packer.sv ====
`include "huff_defs.svh"

module huff_bit_packer (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 code_valid,
	input  huff_pkg::code_beat_t code,
	output logic                 code_ready,
	output logic                 word_valid,
	output huff_pkg::word_t      word,
	input  logic                 word_ready,
	output logic                 done
);
	localparam int WORD_W = `HUFF_WORD_W;
	localparam int ACC_W  = `HUFF_WORD_W + `HUFF_MAX_CODE_LEN;
	localparam int CNT_W  = $clog2(ACC_W + 1);

	// bits gather from the top of acc_q down, unused low bits stay zero
	logic [ACC_W-1:0]              acc_q;
	logic [CNT_W-1:0]              cnt_q;
	logic                          pend_last_q;
	logic                          full_word;
	logic                          final_word;
	logic                          flush_empty;
	logic                          fire;
	logic                          pend_after;
	logic                          accept;
	logic [ACC_W-1:0]              base_acc;
	logic [CNT_W-1:0]              base_cnt;
	logic [`HUFF_MAX_CODE_LEN-1:0] code_mask;
	logic [CNT_W-1:0]              shamt;
	logic [ACC_W-1:0]              code_aligned;

	//////////////////////////////
	// output side
	//////////////////////////////
	assign full_word   = (cnt_q >= CNT_W'(WORD_W));
	// tail of a message, zero padded by construction
	assign final_word  = pend_last_q & (cnt_q != '0) & (cnt_q <= CNT_W'(WORD_W));
	assign flush_empty = pend_last_q & (cnt_q == '0);
	assign word_valid  = full_word | final_word;
	assign word        = acc_q[ACC_W-1 -: WORD_W];
	assign fire        = word_valid & word_ready;
	assign done        = fire & final_word;

	// state left once this cycle's word has gone
	always_comb begin
		base_acc = acc_q;
		base_cnt = cnt_q;
		if (fire) begin
			if (final_word) begin
				base_acc = '0;
				base_cnt = '0;
			end else begin
				base_acc = acc_q << WORD_W;
				base_cnt = cnt_q - CNT_W'(WORD_W);
			end
		end
	end

	//////////////////////////////
	// input side
	//////////////////////////////
	// no new message codes until the tail of this one is out
	assign pend_after = pend_last_q & ~done & ~flush_empty;
	assign code_ready = ~pend_after & (base_cnt < CNT_W'(WORD_W));
	assign accept     = code_valid & code_ready;

	// keep only len bits, msb lands just below the current fill
	assign code_mask    = ~({`HUFF_MAX_CODE_LEN{1'b1}} << code.code.len);
	assign shamt        = CNT_W'(ACC_W) - base_cnt - CNT_W'(code.code.len);
	assign code_aligned = ACC_W'(code.code.bits & code_mask) << shamt;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			acc_q       <= '0;
			cnt_q       <= '0;
			pend_last_q <= 1'b0;
		end else begin
			if (accept) begin
				acc_q <= base_acc | code_aligned;
				cnt_q <= base_cnt + CNT_W'(code.code.len);
			end else begin
				acc_q <= base_acc;
				cnt_q <= base_cnt;
			end
			pend_last_q <= pend_after | (accept & code.last);
		end
	end

endmodule

// ==== rtl/huff_encoder_top.sv ====
`include "huff_defs.svh"

module huff_encoder_top (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [`HUFF_WORD_W-1:0]    in_data,
	input  logic                       in_valid,
	input  logic                       in_end,
	input  logic [2:0]                 last_mask,
	output logic                       in_full,
	input  logic                       tbl_wr,
	input  logic [7:0]                 tbl_sym,
	input  huff_pkg::code_t            tbl_code,
	input  logic                       out_en,
	output huff_pkg::word_t            out_data,
	output logic                       out_valid,
	output logic                       done,
	output logic [`HUFF_MSG_LEN_W-1:0] msg_len
);
	huff_pkg::in_beat_t   in_beat;
	logic                 in_wr_ready;
	logic                 beat_valid;
	huff_pkg::in_beat_t   beat;
	logic                 beat_ready;
	logic                 sym_valid;
	huff_pkg::sym_beat_t  sym;
	logic                 sym_ready;
	logic                 code_valid;
	huff_pkg::code_beat_t code;
	logic                 code_ready;
	logic                 word_valid;
	huff_pkg::word_t      word;
	logic                 word_ready;

	// whole words carry four bytes, the final one its mask
	assign in_beat.data   = in_data;
	assign in_beat.nbytes = in_end ? last_mask : 3'd4;
	assign in_beat.last   = in_end;
	assign in_full        = ~in_wr_ready;

	huff_fifo #(
		.payload_t (huff_pkg::in_beat_t),
		.depth     (`HUFF_IN_DEPTH)
	) u_in_fifo (
		.clk      (clk),
		.rstN     (rstN),
		.wr_valid (in_valid),
		.wr_data  (in_beat),
		.wr_ready (in_wr_ready),
		.rd_valid (beat_valid),
		.rd_data  (beat),
		.rd_ready (beat_ready)
	);

	huff_byte_split u_byte_split (
		.clk       (clk),
		.rstN      (rstN),
		.in_valid  (beat_valid),
		.in_beat   (beat),
		.in_ready  (beat_ready),
		.sym_valid (sym_valid),
		.sym       (sym),
		.sym_ready (sym_ready),
		.msg_len   (msg_len)
	);

	huff_code_lookup u_code_lookup (
		.clk        (clk),
		.rstN       (rstN),
		.tbl_wr     (tbl_wr),
		.tbl_sym    (tbl_sym),
		.tbl_code   (tbl_code),
		.sym_valid  (sym_valid),
		.sym        (sym),
		.sym_ready  (sym_ready),
		.code_valid (code_valid),
		.code       (code),
		.code_ready (code_ready)
	);

	huff_bit_packer u_bit_packer (
		.clk        (clk),
		.rstN       (rstN),
		.code_valid (code_valid),
		.code       (code),
		.code_ready (code_ready),
		.word_valid (word_valid),
		.word       (word),
		.word_ready (word_ready),
		.done       (done)
	);

	huff_fifo #(
		.payload_t (huff_pkg::word_t),
		.depth     (`HUFF_OUT_DEPTH)
	) u_out_fifo (
		.clk      (clk),
		.rstN     (rstN),
		.wr_valid (word_valid),
		.wr_data  (word),
		.wr_ready (word_ready),
		.rd_valid (out_valid),
		.rd_data  (out_data),
		.rd_ready (out_en)
	);

endmodule

// ==== testbench/huff_encoder_asserts.sv ====
module huff_encoder_asserts (
	input logic            clk,
	input logic            rstN,
	input logic            in_valid,
	input logic            in_full,
	input logic            out_valid,
	input logic            out_en,
	input huff_pkg::word_t out_data,
	input logic            done
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	//////////////////////////////
	// output side
	//////////////////////////////
	// head word holds while the consumer waits
	out_hold: assert property (@(posedge clk) disable iff (!rstN)
		out_valid && !out_en |=> $stable(out_data))
		else begin
			$error("out_data changed while out_valid was high and out_en low");
			fail_count++;
		end

	done_pulse: assert property (@(posedge clk) disable iff (!rstN)
		done |=> !done)
		else begin
			$error("done stayed high for two cycles");
			fail_count++;
		end

	//////////////////////////////
	// input side and reset
	//////////////////////////////
	no_overrun: assert property (@(posedge clk) disable iff (!rstN)
		in_full |-> !in_valid)
		else begin
			$error("in_valid high while in_full is high");
			fail_count++;
		end

	// first cycle out of reset
	reset_empty: assert property (@(posedge clk)
		$rose(rstN) |-> !out_valid)
		else begin
			$error("out_valid high right after reset release");
			fail_count++;
		end

endmodule

// ==== testbench/huff_encoder_tb.sv ====
`include "huff_defs.svh"

module huff_encoder_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 2000;

	logic                          clk = 1'b0;
	logic                          rstN;
	logic [`HUFF_WORD_W-1:0]       in_data;
	logic                          in_valid;
	logic                          in_end;
	logic [2:0]                    last_mask;
	logic                          in_full;
	logic                          tbl_wr;
	logic [7:0]                    tbl_sym;
	huff_pkg::code_t               tbl_code;
	logic                          out_en = 1'b0;
	huff_pkg::word_t               out_data;
	logic                          out_valid;
	logic                          done;
	logic [`HUFF_MSG_LEN_W-1:0]    msg_len;

	// shadow of the loaded code table
	int                            code_len [256];
	logic [`HUFF_MAX_CODE_LEN-1:0] code_bits [256];
	logic [31:0]                   exp_words [$];
	int                            exp_lens [$];
	int                            errors = 0;
	int                            timeouts = 0;
	int                            done_count = 0;
	int                            msg_count = 0;
	logic                          hold_pop = 1'b0;
	logic                          saw_full = 1'b0;

	huff_encoder_top dut (.*);

	bind huff_encoder_top huff_encoder_asserts u_asserts (.*);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else begin
			$display("ERROR: %s expected 0x%08h got 0x%08h", name, exp, act);
			errors++;
		end
	endtask

	// reference bitstream with codes msb first and a zero padded tail
	function automatic void encode_message(input logic [7:0] msg_bytes [$]);
		logic [63:0] acc;
		logic [15:0] bits;
		int          cnt;
		int          len;
		acc = '0;
		cnt = 0;
		foreach (msg_bytes[i]) begin
			len  = code_len[msg_bytes[i]];
			bits = code_bits[msg_bytes[i]] & 16'((17'h1 << len) - 17'h1);
			acc  = (acc << len) | 64'(bits);
			cnt += len;
			if (cnt >= 32) begin
				exp_words.push_back(32'(acc >> (cnt - 32)));
				cnt -= 32;
			end
		end
		if (cnt > 0) begin
			exp_words.push_back(32'(acc << (32 - cnt)));
		end
	endfunction

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////
	// kind 0 identity and kind 1 length by symbol with random codes otherwise
	task automatic write_table(input int kind);
		for (int i = 0; i < 256; i++) begin
			case (kind)
				0: begin
					code_len[i]  = 8;
					code_bits[i] = 16'(i);
				end
				1: begin
					code_len[i]  = 1 + (i % 16);
					code_bits[i] = 16'($urandom);
				end
				default: begin
					code_len[i]  = 1 + $urandom_range(15);
					code_bits[i] = 16'($urandom);
				end
			endcase
			@(negedge clk);
			tbl_wr        = 1'b1;
			tbl_sym       = 8'(i);
			tbl_code.len  = 5'(code_len[i]);
			tbl_code.bits = code_bits[i];
		end
		@(negedge clk);
		tbl_wr = 1'b0;
	endtask

	task automatic send_message(input int nwords, input int tail);
		logic [31:0] words [$];
		logic [7:0]  msg_bytes [$];
		logic [31:0] data;
		int          nb;
		int          waited;
		for (int w = 0; w < nwords; w++) begin
			data = $urandom;
			words.push_back(data);
			nb = (w == nwords - 1) ? tail : 4;
			for (int b = 0; b < nb; b++) begin
				msg_bytes.push_back(data[31 - 8 * b -: 8]);
			end
		end
		encode_message(msg_bytes);
		exp_lens.push_back(msg_bytes.size());
		msg_count++;
		for (int w = 0; w < nwords; w++) begin
			@(negedge clk);
			waited = 0;
			while (in_full && waited < TIMEOUT) begin
				in_valid = 1'b0;
				// full input side ends the stall phase
				if (hold_pop) begin
					saw_full = 1'b1;
					hold_pop = 1'b0;
				end
				@(negedge clk);
				waited++;
			end
			if (waited >= TIMEOUT) begin
				$display("timeout: in_full never dropped while sending message %0d",
					msg_count);
				timeouts++;
				in_valid = 1'b0;
				return;
			end
			in_valid  = 1'b1;
			in_data   = words[w];
			in_end    = (w == nwords - 1);
			last_mask = in_end ? 3'(tail) : 3'd4;
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_end   = 1'b0;
	endtask

	task automatic wait_done(input int target);
		int waited;
		waited = 0;
		while (done_count < target && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (done_count < target) begin
			$display("timeout: no done pulse for message %0d", target);
			timeouts++;
		end
	endtask

	//////////////////////////////
	// consumer and done monitor
	//////////////////////////////
	always @(negedge clk) begin : collect
		logic en;
		en = rstN && !hold_pop && ($urandom_range(3) != 0);
		if (en && out_valid) begin
			if (exp_words.size() == 0) begin
				$display("output word 0x%08h arrived with none expected", out_data);
				errors++;
			end else begin
				check_value("out_data", exp_words.pop_front(), out_data);
			end
		end
		out_en = en;
		if (rstN && done) begin
			done_count++;
			if (exp_lens.size() == 0) begin
				$display("done pulsed with no message outstanding");
				errors++;
			end else begin
				check_value("msg_len", 32'(exp_lens.pop_front()), msg_len);
			end
		end
	end

	initial begin
		int waited;
		void'($urandom(49));
		rstN      = 1'b0;
		in_data   = '0;
		in_valid  = 1'b0;
		in_end    = 1'b0;
		last_mask = 3'd4;
		tbl_wr    = 1'b0;
		tbl_sym   = '0;
		tbl_code  = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// reset values
		@(negedge clk);
		check_value("out_valid", 0, out_valid);
		check_value("in_full", 0, in_full);
		check_value("done", 0, done);
		check_value("msg_len", 0, msg_len);

		write_table(0);
		send_message(6, 4);
		wait_done(msg_count);

		// mixed lengths and partial final words
		write_table(1);
		for (int t = 1; t <= 3; t++) begin
			send_message(2 + 2 * t, t);
			wait_done(msg_count);
		end

		// stall the consumer until the input side fills
		hold_pop = 1'b1;
		saw_full = 1'b0;
		send_message(60, 2);
		hold_pop = 1'b0;
		wait_done(msg_count);
		if (!saw_full) begin
			$display("in_full never rose while the consumer was stalled");
			errors++;
		end

		// table rewrite between messages
		write_table(2);
		send_message(8, 3);
		wait_done(msg_count);
		write_table(2);
		send_message(8, 1);
		wait_done(msg_count);

		waited = 0;
		while (exp_words.size() != 0 && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_words.size() != 0) begin
			$display("timeout: %0d output words never arrived", exp_words.size());
			timeouts++;
		end

		// no word may trail the last expected one
		@(negedge clk);
		assert (!out_valid) else begin
			$display("unexpected output word 0x%08h after the last message", out_data);
			errors++;
		end
		check_value("done_count", 32'(msg_count), 32'(done_count));
		errors += dut.u_asserts.fail_count;

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
rtl/huff_pkg.sv
rtl/huff_fifo.sv
rtl/huff_byte_split.sv
rtl/huff_code_lookup.sv
rtl/huff_bit_packer.sv
rtl/huff_encoder_top.sv
testbench/huff_encoder_asserts.sv
testbench/huff_encoder_tb.sv

// ==== Bender.yml ====
package:
  name: huff_encoder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/huff_pkg.sv
      - rtl/huff_fifo.sv
      - rtl/huff_byte_split.sv
      - rtl/huff_code_lookup.sv
      - rtl/huff_bit_packer.sv
      - rtl/huff_encoder_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/huff_encoder_asserts.sv
      - testbench/huff_encoder_tb.sv
